//--- design/alu1_pkg.sv
package alu1_pkg;

    typedef logic [31:0] word_t;
    typedef logic [5:0]  flags_t;
    typedef logic [4:0]  shamt_t;

    // index into flags_t
    typedef enum logic [2:0] {
        CF = 3'd0,
        PF = 3'd1,
        AF = 3'd2,
        ZF = 3'd3,
        SF = 3'd4,
        OF = 3'd5
    } flag_e;

    // 0..7 logic group, 8..12 arithmetic group
    typedef enum logic [3:0] {
        OP_OR      = 4'd0,
        OP_AND     = 4'd1,
        OP_SHL     = 4'd2,
        OP_SHR     = 4'd3,
        OP_PASS_A  = 4'd4,
        OP_PASS_B  = 4'd5,
        OP_ZERO    = 4'd6,
        OP_NOT     = 4'd7,
        OP_INC     = 4'd8,
        OP_ADD     = 4'd9,
        OP_STEP    = 4'd10,
        OP_CMPXCHG = 4'd11,
        OP_DAA     = 4'd12
    } alu1_op_e;

    // x86 EFLAGS bit positions
    localparam int EFLAGS_CF_BIT = 0;
    localparam int EFLAGS_PF_BIT = 2;
    localparam int EFLAGS_AF_BIT = 4;
    localparam int EFLAGS_ZF_BIT = 6;
    localparam int EFLAGS_SF_BIT = 7;
    localparam int EFLAGS_DF_BIT = 10;
    localparam int EFLAGS_OF_BIT = 11;

    // parity, zero and sign of a full word, all other flags clear
    function automatic flags_t szp_flags(word_t value);
        flags_t f;
        f     = '0;
        f[PF] = ~^value[7:0];   // even parity of the low byte
        f[ZF] = ~|value;
        f[SF] = value[31];
        return f;
    endfunction

endpackage

//--- design/alu1_logic.sv
`timescale 1ns/1ps

module alu1_logic
    import alu1_pkg::*;
(
    input  alu1_op_e op,
    input  word_t    sr1,
    input  word_t    sr2,
    output word_t    result,
    output flags_t   flags
);

    shamt_t      shamt;
    logic [32:0] shl_wide;  // bit 32 holds the last bit shifted out
    logic [32:0] shr_wide;  // bit 0 holds the last bit shifted out
    flags_t      unpacked;

    assign shamt    = sr2[4:0];
    assign shl_wide = {1'b0, sr1} << shamt;
    assign shr_wide = {sr1, 1'b0} >> shamt;

    // flags carried in sr1 at their EFLAGS positions
    always_comb
    begin
        unpacked     = '0;
        unpacked[CF] = sr1[EFLAGS_CF_BIT];
        unpacked[PF] = sr1[EFLAGS_PF_BIT];
        unpacked[AF] = sr1[EFLAGS_AF_BIT];
        unpacked[ZF] = sr1[EFLAGS_ZF_BIT];
        unpacked[SF] = sr1[EFLAGS_SF_BIT];
        unpacked[OF] = sr1[EFLAGS_OF_BIT];
    end

    always_comb
    begin
        result = '0;
        flags  = '0;
        case (op)
            OP_OR:
            begin
                result = sr1 | sr2;
                flags  = szp_flags(result);
            end
            OP_AND:
            begin
                result = sr1 & sr2;
                flags  = szp_flags(result);
            end
            OP_SHL:
            begin
                result    = shl_wide[31:0];
                flags     = szp_flags(result);
                flags[CF] = shl_wide[32];                  // zero for a zero count
                flags[OF] = (result[31] == shl_wide[32]);
            end
            OP_SHR:
            begin
                result    = shr_wide[32:1];
                flags     = szp_flags(result);
                flags[CF] = shr_wide[0];
            end
            OP_PASS_A:
            begin
                result = sr1;
                flags  = unpacked;
            end
            OP_PASS_B:
            begin
                result = sr2;
                flags  = unpacked;
            end
            OP_ZERO:
            begin
                result = '0;
                flags  = unpacked;
            end
            OP_NOT:
            begin
                result = ~sr1;
                flags  = unpacked;
            end
            default:
            begin
                result = '0;    // arithmetic group is handled elsewhere
                flags  = '0;
            end
        endcase
    end

endmodule

//--- design/alu1_arith.sv
`timescale 1ns/1ps

module alu1_arith
    import alu1_pkg::*;
#(
    parameter word_t STEP_SIZE = 32'd4
)
(
    input  alu1_op_e op,
    input  word_t    sr1,
    input  word_t    sr2,
    input  word_t    eax,
    input  logic     cf_in,
    input  logic     af_in,
    input  logic     df_in,
    output word_t    result,
    output flags_t   flags
);

    word_t       addend;
    logic [32:0] sum_wide;
    logic [4:0]  sum_nib;
    logic [32:0] diff_wide;     // eax - sr1, bit 32 is the borrow
    logic [4:0]  diff_nib;
    word_t       step_res;
    logic [7:0]  daa_lo;
    logic        daa_af;
    logic        daa_cf;

    // increment and add share one adder
    assign addend   = (op == OP_INC) ? 32'd1 : sr2;
    assign sum_wide = {1'b0, sr1} + {1'b0, addend};
    assign sum_nib  = {1'b0, sr1[3:0]} + {1'b0, addend[3:0]};

    assign diff_wide = {1'b0, eax} - {1'b0, sr1};
    assign diff_nib  = {1'b0, eax[3:0]} - {1'b0, sr1[3:0]};

    assign step_res = df_in ? (sr1 - STEP_SIZE) : (sr1 + STEP_SIZE);

    // decimal adjust, both corrections test the original eax
    always_comb
    begin
        daa_af = (eax[3:0] > 4'h9) | af_in;
        daa_cf = (eax[7:0] > 8'h99) | cf_in;
        daa_lo = eax[7:0];
        if (daa_af)
            daa_lo = daa_lo + 8'h06;
        if (daa_cf)
            daa_lo = daa_lo + 8'h60;
    end

    always_comb
    begin
        result = '0;
        flags  = '0;
        case (op)
            OP_INC, OP_ADD:
            begin
                result    = sum_wide[31:0];
                flags     = szp_flags(result);
                flags[CF] = sum_wide[32];
                flags[AF] = sum_nib[4];
                flags[OF] = (sr1[31] == addend[31]) && (result[31] != sr1[31]);
            end
            OP_STEP:
            begin
                result = step_res;  // pointer update leaves flags clear
                flags  = '0;
            end
            OP_CMPXCHG:
            begin
                result    = sr1;
                flags     = szp_flags(diff_wide[31:0]);
                flags[CF] = diff_wide[32];
                flags[AF] = diff_nib[4];
                flags[OF] = (eax[31] != sr1[31]) && (diff_wide[31] != eax[31]);
            end
            OP_DAA:
            begin
                result    = {eax[31:8], daa_lo};
                flags[CF] = daa_cf;
                flags[PF] = ~^daa_lo;
                flags[AF] = daa_af;
                flags[ZF] = ~|daa_lo;
                flags[SF] = daa_lo[7];
            end
            default:
            begin
                result = '0;
                flags  = '0;
            end
        endcase
    end

endmodule

//--- design/alu1_cmps.sv
`timescale 1ns/1ps

module alu1_cmps
    import alu1_pkg::*;
(
    input  word_t  mem_out_latched,
    input  word_t  mem_out,
    output flags_t flags
);

    logic [32:0] diff_wide;
    logic [4:0]  diff_nib;
    word_t       diff;

    // two's complement add, so CF and AF are set when nothing was borrowed
    assign diff_wide = {1'b0, mem_out_latched} + {1'b0, ~mem_out} + 33'd1;
    assign diff_nib  = {1'b0, mem_out_latched[3:0]} + {1'b0, ~mem_out[3:0]} + 5'd1;
    assign diff      = diff_wide[31:0];

    always_comb
    begin
        flags     = szp_flags(diff);
        flags[CF] = diff_wide[32];
        flags[AF] = diff_nib[4];
        // operands of opposite sign, result sign differs from the minuend
        flags[OF] = (mem_out_latched[31] != mem_out[31])
                    && (diff[31] != mem_out_latched[31]);
    end

endmodule

//--- design/alu1_stage.sv
`timescale 1ns/1ps

module alu1_stage
    import alu1_pkg::*;
#(
    parameter word_t STEP_SIZE = 32'd4
)
(
    input  logic     clk,
    input  logic     rst,
    input  alu1_op_e alu1_op,
    input  word_t    sr1,
    input  word_t    sr2,
    input  word_t    eax,
    input  word_t    mem_out,
    input  word_t    mem_out_latched,
    input  logic     cf_in,
    input  logic     af_in,
    input  logic     df_in,
    input  logic     df_val,
    input  logic     isr,
    input  flags_t   ld_flag_in,
    output word_t    alu_res1,
    output flags_t   alu1_flags,
    output flags_t   cmps_flags,
    output logic     df_val_ex,
    output flags_t   ld_flag
);

    word_t  logic_res;
    flags_t logic_flags;
    word_t  arith_res;
    flags_t arith_flags;
    flags_t cmps_next;
    shamt_t shamt;
    logic   op_defined;
    logic   arith_sel;
    logic   zero_shift;

    alu1_logic i_alu1_logic (
        .op     (alu1_op),
        .sr1    (sr1),
        .sr2    (sr2),
        .result (logic_res),
        .flags  (logic_flags)
    );

    alu1_arith #(
        .STEP_SIZE (STEP_SIZE)
    ) i_alu1_arith (
        .op     (alu1_op),
        .sr1    (sr1),
        .sr2    (sr2),
        .eax    (eax),
        .cf_in  (cf_in),
        .af_in  (af_in),
        .df_in  (df_in),
        .result (arith_res),
        .flags  (arith_flags)
    );

    alu1_cmps i_alu1_cmps (
        .mem_out_latched (mem_out_latched),
        .mem_out         (mem_out),
        .flags           (cmps_next)
    );

    assign shamt      = sr2[4:0];
    assign op_defined = (alu1_op <= OP_DAA);   // 13..15 hold state
    assign arith_sel  = (alu1_op >= OP_INC);
    assign zero_shift = ((alu1_op == OP_SHL) || (alu1_op == OP_SHR)) && (shamt == '0);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            alu_res1   <= '0;
            alu1_flags <= '0;
            cmps_flags <= '0;
            df_val_ex  <= 1'b0;
            ld_flag    <= '0;
        end
        else if (op_defined)
        begin
            alu_res1   <= arith_sel ? arith_res : logic_res;
            alu1_flags <= arith_sel ? arith_flags : logic_flags;
            cmps_flags <= cmps_next;
            df_val_ex  <= isr ? sr2[EFLAGS_DF_BIT] : df_val;  // interrupt return restores DF
            ld_flag    <= zero_shift ? flags_t'('0) : ld_flag_in;
        end
    end

    a_op_defined : assert property (@(posedge clk) disable iff (rst)
        alu1_op <= OP_DAA);

    // a shift by zero must not disturb any flag in the next stage
    a_zero_shift_no_load : assert property (@(posedge clk) disable iff (rst)
        zero_shift |=> (ld_flag == '0));

    a_step_flags_clear : assert property (@(posedge clk) disable iff (rst)
        (alu1_op == OP_STEP) |=> ((alu1_flags[AF] | alu1_flags[OF]) == 1'b0));

endmodule

//--- bench/alu1_model.svh
`ifndef ALU1_MODEL_SVH
`define ALU1_MODEL_SVH

// expects STEP_SIZE from the enclosing module

function automatic logic low_byte_parity(logic [7:0] b);
    return ($countones(b) % 2) == 0;    // PF set on an even count of ones
endfunction

function automatic flags_t result_flags(word_t r);
    flags_t f;
    f     = '0;
    f[PF] = low_byte_parity(r[7:0]);
    f[ZF] = (r == 32'd0);
    f[SF] = r[31];
    return f;
endfunction

function automatic flags_t eflags_unpack(word_t w);
    flags_t f;
    f     = '0;
    f[CF] = w[EFLAGS_CF_BIT];
    f[PF] = w[EFLAGS_PF_BIT];
    f[AF] = w[EFLAGS_AF_BIT];
    f[ZF] = w[EFLAGS_ZF_BIT];
    f[SF] = w[EFLAGS_SF_BIT];
    f[OF] = w[EFLAGS_OF_BIT];
    return f;
endfunction

function automatic logic [7:0] daa_low_byte(logic [7:0] lo, logic af, logic cf);
    logic [7:0] v;
    v = lo;
    if ((lo[3:0] > 4'h9) || af)
        v = v + 8'h06;
    if ((lo > 8'h99) || cf)    // tested on the original byte
        v = v + 8'h60;
    return v;
endfunction

function automatic word_t alu1_ref_result(alu1_op_e op, word_t a, word_t b, word_t e,
                                          logic cf, logic af, logic df);
    word_t r;
    case (op)
        OP_OR:      r = a | b;
        OP_AND:     r = a & b;
        OP_SHL:     r = a << b[4:0];
        OP_SHR:     r = a >> b[4:0];
        OP_PASS_A:  r = a;
        OP_PASS_B:  r = b;
        OP_ZERO:    r = 32'd0;
        OP_NOT:     r = ~a;
        OP_INC:     r = a + 32'd1;
        OP_ADD:     r = a + b;
        OP_STEP:    r = df ? (a - STEP_SIZE) : (a + STEP_SIZE);
        OP_CMPXCHG: r = a;
        OP_DAA:     r = {e[31:8], daa_low_byte(e[7:0], af, cf)};
        default:    r = 32'd0;
    endcase
    return r;
endfunction

function automatic flags_t alu1_ref_flags(alu1_op_e op, word_t a, word_t b, word_t e,
                                          logic cf, logic af, logic df);
    int         n;
    word_t      r;
    word_t      addend;
    word_t      carries;
    word_t      shifted;
    longint     sd;
    logic [7:0] lo;
    flags_t     f;
    n = int'(b[4:0]);
    r = alu1_ref_result(op, a, b, e, cf, af, df);
    f = '0;
    case (op)
        OP_OR, OP_AND:
            f = result_flags(r);
        OP_SHL:
        begin
            f         = result_flags(r);
            shifted   = (n == 0) ? 32'd0 : (a >> (32 - n));
            f[CF]     = shifted[0];
            f[OF]     = (r[31] == f[CF]);
        end
        OP_SHR:
        begin
            f         = result_flags(r);
            shifted   = (n == 0) ? 32'd0 : (a >> (n - 1));
            f[CF]     = shifted[0];
        end
        OP_PASS_A, OP_PASS_B, OP_ZERO, OP_NOT:
            f = eflags_unpack(a);
        OP_INC, OP_ADD:
        begin
            addend  = (op == OP_INC) ? 32'd1 : b;
            carries = a ^ addend ^ r;       // carry into each bit
            f       = result_flags(r);
            f[CF]   = (r < a);               // sum wrapped around
            f[AF]   = carries[4];
            f[OF]   = (a[31] == addend[31]) && (r[31] != a[31]);
        end
        OP_CMPXCHG:
        begin
            sd    = longint'($signed(e)) - longint'($signed(a));
            f     = result_flags(e - a);
            f[CF] = (e < a);
            f[AF] = (e[3:0] < a[3:0]);
            f[OF] = (sd > 64'sd2147483647) || (sd < -64'sd2147483648);
        end
        OP_DAA:
        begin
            lo    = r[7:0];
            f[CF] = (e[7:0] > 8'h99) || cf;
            f[AF] = (e[3:0] > 4'h9) || af;
            f[PF] = low_byte_parity(lo);
            f[ZF] = (lo == 8'd0);
            f[SF] = lo[7];
        end
        default:
            f = '0;     // step leaves all flags clear
    endcase
    return f;
endfunction

function automatic flags_t alu1_ref_cmps(word_t ml, word_t m);
    longint sd;
    flags_t f;
    sd    = longint'($signed(ml)) - longint'($signed(m));
    f     = result_flags(ml - m);
    f[CF] = (ml >= m);      // set when nothing is borrowed
    f[AF] = (ml[3:0] >= m[3:0]);
    f[OF] = (sd > 64'sd2147483647) || (sd < -64'sd2147483648);
    return f;
endfunction

function automatic logic alu1_ref_df(logic from_isr, word_t b, logic dfv);
    return from_isr ? b[EFLAGS_DF_BIT] : dfv;
endfunction

function automatic flags_t alu1_ref_ld(alu1_op_e op, word_t b, flags_t ld_in);
    if (((op == OP_SHL) || (op == OP_SHR)) && (b[4:0] == 5'd0))
        return '0;
    return ld_in;
endfunction

`endif

//--- bench/alu1_tb.sv
`timescale 1ns/1ps

module alu1_tb
    import alu1_pkg::*;
();

    localparam word_t STEP_SIZE = 32'd4;

    logic     clk;
    logic     rst;
    alu1_op_e alu1_op;
    word_t    sr1;
    word_t    sr2;
    word_t    eax;
    word_t    mem_out;
    word_t    mem_out_latched;
    logic     cf_in;
    logic     af_in;
    logic     df_in;
    logic     df_val;
    logic     isr;
    flags_t   ld_flag_in;
    word_t    alu_res1;
    flags_t   alu1_flags;
    flags_t   cmps_flags;
    logic     df_val_ex;
    flags_t   ld_flag;

    // expected outputs for the operation applied before the next rising edge
    word_t    exp_res;
    flags_t   exp_flags;
    flags_t   exp_cmps;
    flags_t   exp_ld;
    logic     exp_df;
    logic     exp_valid;

    int       checks;
    int       errors;
    int       test_err_base;

    `include "alu1_model.svh"

    alu1_stage #(
        .STEP_SIZE (STEP_SIZE)
    ) i_alu1_stage (
        .clk             (clk),
        .rst             (rst),
        .alu1_op         (alu1_op),
        .sr1             (sr1),
        .sr2             (sr2),
        .eax             (eax),
        .mem_out         (mem_out),
        .mem_out_latched (mem_out_latched),
        .cf_in           (cf_in),
        .af_in           (af_in),
        .df_in           (df_in),
        .df_val          (df_val),
        .isr             (isr),
        .ld_flag_in      (ld_flag_in),
        .alu_res1        (alu_res1),
        .alu1_flags      (alu1_flags),
        .cmps_flags      (cmps_flags),
        .df_val_ex       (df_val_ex),
        .ld_flag         (ld_flag)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #5 rst = 1'b0;
    end

    task automatic check_word(string name, word_t exp, word_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flags(string name, flags_t exp, flags_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_outputs_zero();
        check_word("alu_res1", '0, alu_res1);
        check_flags("alu1_flags", '0, alu1_flags);
        check_flags("cmps_flags", '0, cmps_flags);
        check_bit("df_val_ex", 1'b0, df_val_ex);
        check_flags("ld_flag", '0, ld_flag);
    endtask

    // outputs are registered, so compare shortly after each rising edge
    initial
    begin
        forever
        begin
            @(posedge clk);
            #2;
            if (exp_valid)
            begin
                check_word("alu_res1", exp_res, alu_res1);
                check_flags("alu1_flags", exp_flags, alu1_flags);
                check_flags("cmps_flags", exp_cmps, cmps_flags);
                check_bit("df_val_ex", exp_df, df_val_ex);
                check_flags("ld_flag", exp_ld, ld_flag);
            end
        end
    end

    function automatic word_t rand_word();
        word_t w;
        w = $urandom;
        return w;
    endfunction

    function automatic logic rand_bit();
        word_t w;
        w = $urandom;
        return w[0];
    endfunction

    function automatic alu1_op_e op_from_int(int v);
        return alu1_op_e'(v[3:0]);
    endfunction

    function automatic alu1_op_e random_logic_op();
        int v;
        v = $urandom_range(7, 0);
        if ((v == 2) || (v == 3))
            v = v + 2;      // shifts have their own test
        return op_from_int(v);
    endfunction

    task automatic apply_op(alu1_op_e op, word_t a, word_t b, word_t e,
                            logic c, logic af, logic d);
        word_t w;
        @(negedge clk);
        w               = $urandom;
        alu1_op         = op;
        sr1             = a;
        sr2             = b;
        eax             = e;
        cf_in           = c;
        af_in           = af;
        df_in           = d;
        mem_out         = rand_word();
        mem_out_latched = (w[1:0] == 2'd0) ? mem_out : rand_word();
        df_val          = rand_bit();
        isr             = rand_bit();
        ld_flag_in      = flags_t'(rand_word());
        exp_res         = alu1_ref_result(op, a, b, e, c, af, d);
        exp_flags       = alu1_ref_flags(op, a, b, e, c, af, d);
        exp_cmps        = alu1_ref_cmps(mem_out_latched, mem_out);
        exp_df          = alu1_ref_df(isr, b, df_val);
        exp_ld          = alu1_ref_ld(op, b, ld_flag_in);
        exp_valid       = 1'b1;
    endtask

    task automatic apply_random(alu1_op_e op);
        apply_op(op, rand_word(), rand_word(), rand_word(), rand_bit(), rand_bit(), rand_bit());
    endtask

    task automatic wait_last_compare();
        @(posedge clk);
        #5;
    endtask

    task automatic report_test(string name, int ops);
        $display("test %s: %0d ops, %0d errors", name, ops, errors - test_err_base);
        test_err_base = errors;
    endtask

    task automatic wait_reset_release(output logic released);
        released = 1'b0;
        for (int n = 0; (n < 10) && !released; n++)
        begin
            @(negedge clk);
            if (rst)
                check_outputs_zero();
            else
                released = 1'b1;
        end
    endtask

    initial
    begin
        logic  released;
        word_t b;
        void'($urandom(35));
        alu1_op         = OP_OR;
        sr1             = '0;
        sr2             = '0;
        eax             = '0;
        mem_out         = '0;
        mem_out_latched = '0;
        cf_in           = 1'b0;
        af_in           = 1'b0;
        df_in           = 1'b0;
        df_val          = 1'b0;
        isr             = 1'b0;
        ld_flag_in      = '0;
        exp_valid       = 1'b0;
        checks          = 0;
        errors          = 0;
        test_err_base   = 0;

        wait_reset_release(released);
        if (!released)
        begin
            $display("reset was not released within 10 clock cycles");
            $display("TESTS FAILED");
            $finish;
        end
        else
        begin
            check_outputs_zero();   // still clear right after release
            report_test("reset", 0);

            for (int i = 0; i < 200; i++)
                apply_random(random_logic_op());
            wait_last_compare();
            report_test("logic_random", 200);

            apply_op(OP_SHL, 32'h8000_0001, 32'hFFFF_FFE0, '0, 1'b0, 1'b0, 1'b0);
            apply_op(OP_SHR, 32'h8000_0001, 32'h0000_0000, '0, 1'b0, 1'b0, 1'b0);
            apply_op(OP_SHL, 32'h8000_0001, 32'h0000_0001, '0, 1'b0, 1'b0, 1'b0);
            apply_op(OP_SHL, 32'h0000_0003, 32'h0000_001F, '0, 1'b0, 1'b0, 1'b0);
            apply_op(OP_SHR, 32'hC000_0000, 32'h0000_001F, '0, 1'b0, 1'b0, 1'b0);
            for (int i = 0; i < 100; i++)
            begin
                b = rand_word();
                if ((i % 4) == 0)
                    b[4:0] = 5'd0;
                apply_op((i % 2) ? OP_SHR : OP_SHL, rand_word(), b, rand_word(),
                         rand_bit(), rand_bit(), rand_bit());
            end
            wait_last_compare();
            report_test("shift", 105);

            for (int i = 0; i < 200; i++)
                apply_random(op_from_int($urandom_range(12, 8)));
            apply_op(OP_INC, 32'h7FFF_FFFF, rand_word(), rand_word(), 1'b0, 1'b0, 1'b0);
            apply_op(OP_INC, 32'hFFFF_FFFF, rand_word(), rand_word(), 1'b0, 1'b0, 1'b0);
            apply_op(OP_STEP, 32'h0000_1000, rand_word(), rand_word(), 1'b0, 1'b0, 1'b0);
            apply_op(OP_STEP, 32'h0000_1000, rand_word(), rand_word(), 1'b0, 1'b0, 1'b1);
            apply_op(OP_STEP, 32'h0000_0000, rand_word(), rand_word(), 1'b0, 1'b0, 1'b1);
            apply_op(OP_CMPXCHG, 32'h1234_5678, rand_word(), 32'h1234_5678, 1'b0, 1'b0, 1'b0);
            apply_op(OP_CMPXCHG, 32'h8000_0000, rand_word(), 32'h8000_0000, 1'b1, 1'b1, 1'b0);
            apply_op(OP_DAA, rand_word(), rand_word(), 32'h1234_567B, 1'b0, 1'b0, 1'b0);
            apply_op(OP_DAA, rand_word(), rand_word(), 32'h0000_0012, 1'b0, 1'b1, 1'b0);
            apply_op(OP_DAA, rand_word(), rand_word(), 32'h0000_0045, 1'b1, 1'b0, 1'b0);
            apply_op(OP_DAA, rand_word(), rand_word(), 32'hABCD_EFA5, 1'b0, 1'b0, 1'b0);
            apply_op(OP_DAA, rand_word(), rand_word(), 32'h0000_009F, 1'b0, 1'b0, 1'b0);
            wait_last_compare();
            report_test("arith", 212);

            // every op also checks cmps_flags and df_val_ex, here across all opcodes
            for (int i = 0; i < 100; i++)
                apply_random(op_from_int($urandom_range(12, 0)));
            wait_last_compare();
            report_test("cmps_df", 100);

            for (int i = 0; i < 39; i++)
                apply_random(op_from_int((i * 5) % 13));  // new opcode each cycle
            wait_last_compare();
            report_test("back_to_back", 39);

            $display("checks %0d, errors %0d", checks, errors);
            if (errors == 0)
                $display("TESTS PASSED");
            else
                $display("TESTS FAILED");
            $finish;
        end
    end

endmodule

//--- list.f
+incdir+bench
design/alu1_pkg.sv
design/alu1_logic.sv
design/alu1_arith.sv
design/alu1_cmps.sv
design/alu1_stage.sv
bench/alu1_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= alu1_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST) design/*.sv bench/*.sv bench/*.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
